//--- rtl/l2_pkg.sv
// package defaults set every struct width; a top-level num_sets must match 1 << set_bits
package l2_pkg;

    localparam int word_w         = 32;
    localparam int words_per_line = 4;
    localparam int num_ways       = 4;                      // PLRU tree assumes four
    localparam int set_bits       = 4;
    localparam int num_sets       = 1 << set_bits;
    localparam int addr_w         = 16;                     // word address
    localparam int offset_bits    = $clog2(words_per_line);
    localparam int tag_bits       = addr_w - set_bits - offset_bits;
    localparam int line_w         = word_w * words_per_line;
    localparam int line_addr_w    = addr_w - offset_bits;

    typedef logic [word_w-1:0] word_t;
    typedef logic [line_w-1:0] line_t;
    typedef logic [1:0]        way_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic  dirty;
        line_t line;
    } data_entry_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              write;
        word_t             wdata;
    } l2_req_t;

    typedef struct packed {
        word_t data;
        logic  src;                                         // 0 instruction, 1 data
        logic  write;
    } l2_rsp_t;

    typedef struct packed {
        logic [line_addr_w-1:0] line_addr;
        logic                   write;
        line_t                  data;
    } mem_req_t;

    typedef struct packed {
        line_t data;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        write_back,
        refill,
        respond
    } ctrl_state_t;

endpackage

//--- rtl/l2_way_array.sv
// stored entries are unknown after reset until the controller's clear sweep has written them
module l2_way_array #(
    parameter type entry_t  = logic,
    parameter int  num_sets = l2_pkg::num_sets
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rd_en,
    input  logic [$clog2(num_sets)-1:0] rd_set,
    output entry_t                      rd_entries [l2_pkg::num_ways],
    input  logic                        wr_en,
    input  logic [$clog2(num_sets)-1:0] wr_set,
    input  l2_pkg::way_t                wr_way,
    input  entry_t                      wr_entry
);
    import l2_pkg::*;

    entry_t store [num_sets][num_ways];

    // one way per write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            store[wr_set][wr_way] <= wr_entry;
        end
    end

    // all ways of a set come out together, held until the next read
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_ways; w++) begin
                rd_entries[w] <= '0;
            end
        end else if (rd_en) begin
            for (int w = 0; w < num_ways; w++) begin
                rd_entries[w] <= store[rd_set][w];
            end
        end
    end

    // controller must not read a set in the same cycle as it writes it
    assert property (@(posedge clk) disable iff (reset)
        rd_en && wr_en |-> rd_set != wr_set);

endmodule

//--- rtl/l2_way_select.sv
// PLRU state is indexed by touch_set, which must carry the looked-up set during lookup too
module l2_way_select #(
    parameter int num_sets = l2_pkg::num_sets
) (
    input  logic                        clk,
    input  logic                        reset,
    input  l2_pkg::tag_entry_t          tags [l2_pkg::num_ways],
    input  logic [l2_pkg::tag_bits-1:0] look_tag,
    output logic                        hit,
    output l2_pkg::way_t                hit_way,
    output l2_pkg::way_t                victim_way,
    output logic [l2_pkg::tag_bits-1:0] victim_tag,
    input  logic                        touch_en,
    input  logic [$clog2(num_sets)-1:0] touch_set,
    input  l2_pkg::way_t                touch_way
);
    import l2_pkg::*;

    logic [num_ways-1:0] match;
    logic [2:0]          plru [num_sets];   // [0] root, [1] ways 0/1, [2] ways 2/3
    logic [2:0]          tree;
    logic                all_valid;

    ////////////////////////////////////////
    // tag compare

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin     // downward, lowest way wins
            match[w] = tags[w].valid && tags[w].tag == look_tag;
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    ////////////////////////////////////////
    // victim choice

    assign tree = plru[touch_set];

    always_comb begin
        all_valid  = 1'b1;
        victim_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!tags[w].valid) begin
                all_valid  = 1'b0;
                victim_way = way_t'(w);
            end
        end
        if (all_valid) begin
            victim_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};   // bit low = go low
        end
    end

    assign victim_tag = tags[victim_way].tag;

    // bits on the path point away from the touched way
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                plru[s] <= '0;
            end
        end else if (touch_en) begin
            plru[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                plru[touch_set][2] <= ~touch_way[0];
            end else begin
                plru[touch_set][1] <= ~touch_way[0];
            end
        end
    end

    // refill only on a miss, so a tag never lives in two ways of a set
    assert property (@(posedge clk) disable iff (reset) $onehot0(match));

endmodule

//--- rtl/l2_req_arbiter.sv
// one request held at a time; dc_ready stays low while ic_valid is high
module l2_req_arbiter (
    input  logic            clk,
    input  logic            reset,
    input  l2_pkg::l2_req_t ic_req,
    input  logic            ic_valid,
    output logic            ic_ready,
    input  l2_pkg::l2_req_t dc_req,
    input  logic            dc_valid,
    output logic            dc_ready,
    output l2_pkg::l2_req_t held_req,
    output logic            held_src,
    output logic            req_pending,
    input  logic            done,
    input  logic            en
);
    logic ic_fire;
    logic dc_fire;

    assign ic_ready = en && !req_pending;
    assign dc_ready = en && !req_pending && !ic_valid;     // instruction side first
    assign ic_fire  = ic_valid && ic_ready;
    assign dc_fire  = dc_valid && dc_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= 1'b0;
        end else if (done) begin
            req_pending <= 1'b0;                            // response taken
        end else if (ic_fire || dc_fire) begin
            req_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ic_fire) begin
            held_req <= ic_req;
            held_src <= 1'b0;
        end else if (dc_fire) begin
            held_req <= dc_req;
            held_src <= 1'b1;
        end
    end

endmodule

//--- rtl/l2_ctrl_fsm.sv
// one request at a time; write-back and refill each move a whole line in a single beat
module l2_ctrl_fsm #(
    parameter int num_sets       = l2_pkg::num_sets,
    parameter int words_per_line = l2_pkg::words_per_line
) (
    input  logic                        clk,
    input  logic                        reset,
    input  l2_pkg::l2_req_t             held_req,
    input  logic                        held_src,
    input  logic                        req_pending,
    output logic                        done,
    output logic                        en,
    output logic                        rd_en,
    output logic [$clog2(num_sets)-1:0] rd_set,
    output logic [$clog2(num_sets)-1:0] wr_set,
    output l2_pkg::way_t                wr_way,
    output logic                        tag_wr_en,
    output l2_pkg::tag_entry_t          tag_wr_entry,
    output logic                        data_wr_en,
    output l2_pkg::data_entry_t         data_wr_entry,
    input  l2_pkg::data_entry_t         data_rd [l2_pkg::num_ways],
    output logic [l2_pkg::tag_bits-1:0] look_tag,
    input  logic                        hit,
    input  l2_pkg::way_t                hit_way,
    input  l2_pkg::way_t                victim_way,
    input  logic [l2_pkg::tag_bits-1:0] victim_tag,
    output logic                        touch_en,
    output logic [$clog2(num_sets)-1:0] touch_set,
    output l2_pkg::way_t                touch_way,
    output l2_pkg::l2_rsp_t             rsp,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output l2_pkg::mem_req_t            mem_req,
    output logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    input  l2_pkg::mem_rsp_t            mem_rsp,
    input  logic                        mem_rsp_valid,
    output logic                        mem_rsp_ready
);
    import l2_pkg::*;

    localparam int idx_w = $clog2(num_sets);

    ctrl_state_t            state;
    logic                   clearing;       // post-reset sweep
    logic [idx_w+1:0]       clr_cnt;        // {set, way}
    logic                   merge_q;        // write hit, merge cycle next
    way_t                   way_q;
    logic [idx_w-1:0]       index;
    logic [offset_bits-1:0] offset;
    logic                   mem_rsp_fire;
    line_t                  base_line;
    line_t                  new_line;

    function automatic word_t pick_word(line_t line, logic [offset_bits-1:0] off);
        return line[off*word_w +: word_w];
    endfunction

    function automatic line_t put_word(line_t line, logic [offset_bits-1:0] off, word_t wd);
        line_t merged;
        merged = line;
        for (int w = 0; w < words_per_line; w++) begin
            if (int'(off) == w) begin
                merged[w*word_w +: word_w] = wd;
            end
        end
        return merged;
    endfunction

    assign index    = held_req.addr[offset_bits +: idx_w];
    assign offset   = held_req.addr[offset_bits-1:0];
    assign look_tag = held_req.addr[addr_w-1 -: tag_bits];

    assign en            = !clearing;
    assign done          = rsp_valid && rsp_ready;
    assign mem_rsp_ready = (state == write_back || state == refill) && !mem_req_valid;
    assign mem_rsp_fire  = mem_rsp_valid && mem_rsp_ready;

    assign rd_en     = state == idle && req_pending;
    assign rd_set    = index;
    assign touch_en  = done;                        // every access, once
    assign touch_set = index;
    assign touch_way = way_q;

    // hit line in lookup, memory line in refill; write word merged over either
    assign base_line = (state == lookup) ? data_rd[hit_way].line : mem_rsp.data;
    assign new_line  = held_req.write ? put_word(base_line, offset, held_req.wdata) : base_line;

    ////////////////////////////////////////
    // array writes

    always_comb begin
        tag_wr_en     = clearing || (state == refill && mem_rsp_fire);
        data_wr_en    = tag_wr_en || (state == lookup && merge_q);
        wr_set        = clearing ? clr_cnt[idx_w+1:2] : index;
        wr_way        = clearing ? clr_cnt[1:0] : way_q;
        tag_wr_entry  = '{valid: !clearing, tag: look_tag};
        data_wr_entry = '{dirty: held_req.write && !clearing, line: new_line};
    end

    ////////////////////////////////////////
    // state and handshakes

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= idle;
            clearing      <= 1'b1;
            clr_cnt       <= '0;
            merge_q       <= 1'b0;
            rsp_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            if (clearing) begin
                clr_cnt  <= clr_cnt + 1'b1;
                clearing <= clr_cnt != '1;
            end
            if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            case (state)
                idle: begin
                    if (rd_en) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (hit && held_req.write && !merge_q) begin
                        merge_q <= 1'b1;            // stay one more cycle to merge
                    end else if (hit) begin
                        merge_q   <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= respond;
                    end else begin
                        mem_req_valid <= 1'b1;      // dirty lines are always valid
                        state <= data_rd[victim_way].dirty ? write_back : refill;
                    end
                end
                write_back: begin
                    if (mem_rsp_fire) begin
                        mem_req_valid <= 1'b1;      // now fetch the missed line
                        state         <= refill;
                    end
                end
                refill: begin
                    if (mem_rsp_fire) begin
                        rsp_valid <= 1'b1;
                        state     <= respond;
                    end
                end
                respond: begin
                    if (done) begin
                        rsp_valid <= 1'b0;
                        state     <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lookup) begin
            way_q         <= hit ? hit_way : victim_way;
            mem_req.write <= data_rd[victim_way].dirty;
            mem_req.data  <= data_rd[victim_way].line;
            mem_req.line_addr <= data_rd[victim_way].dirty ? {victim_tag, index}
                                                           : held_req.addr[addr_w-1:offset_bits];
        end
        if (state == write_back && mem_rsp_fire) begin
            mem_req.line_addr <= held_req.addr[addr_w-1:offset_bits];
            mem_req.write     <= 1'b0;
        end
        if (!rsp_valid) begin                       // frozen while waiting on rsp_ready
            rsp <= '{data: pick_word(new_line, offset), src: held_src, write: held_req.write};
        end
    end

    // memory request stays up and unchanged until memory takes it
    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

//--- rtl/l2_cache_top.sv
// single outstanding request; ic_ready and dc_ready stay low until the reset clear sweep ends
module l2_cache_top #(
    parameter int num_sets       = l2_pkg::num_sets,
    parameter int words_per_line = l2_pkg::words_per_line
) (
    input  logic             clk,
    input  logic             reset,
    input  l2_pkg::l2_req_t  ic_req,
    input  logic             ic_valid,
    output logic             ic_ready,
    input  l2_pkg::l2_req_t  dc_req,
    input  logic             dc_valid,
    output logic             dc_ready,
    output l2_pkg::l2_rsp_t  rsp,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output l2_pkg::mem_req_t mem_req,
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    input  l2_pkg::mem_rsp_t mem_rsp,
    input  logic             mem_rsp_valid,
    output logic             mem_rsp_ready
);
    import l2_pkg::*;

    localparam int idx_w = $clog2(num_sets);

    l2_req_t             held_req;
    logic                held_src;
    logic                req_pending;
    logic                done;
    logic                en;
    logic                rd_en;
    logic [idx_w-1:0]    rd_set;
    logic [idx_w-1:0]    wr_set;
    way_t                wr_way;
    logic                tag_wr_en;
    tag_entry_t          tag_wr_entry;
    logic                data_wr_en;
    data_entry_t         data_wr_entry;
    tag_entry_t          tag_rd [num_ways];
    data_entry_t         data_rd [num_ways];
    logic [tag_bits-1:0] look_tag;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic [tag_bits-1:0] victim_tag;
    logic                touch_en;
    logic [idx_w-1:0]    touch_set;
    way_t                touch_way;

    ////////////////////////////////////////
    // request side

    l2_req_arbiter arb_i (
        .clk, .reset, .ic_req, .ic_valid, .ic_ready, .dc_req, .dc_valid, .dc_ready,
        .held_req, .held_src, .req_pending, .done, .en
    );

    ////////////////////////////////////////
    // storage and lookup

    l2_way_array #(.entry_t(tag_entry_t), .num_sets(num_sets)) tag_array_i (
        .clk, .reset, .rd_en, .rd_set, .rd_entries(tag_rd),
        .wr_en(tag_wr_en), .wr_set, .wr_way, .wr_entry(tag_wr_entry)
    );

    l2_way_array #(.entry_t(data_entry_t), .num_sets(num_sets)) data_array_i (
        .clk, .reset, .rd_en, .rd_set, .rd_entries(data_rd),
        .wr_en(data_wr_en), .wr_set, .wr_way, .wr_entry(data_wr_entry)
    );

    l2_way_select #(.num_sets(num_sets)) sel_i (
        .clk, .reset, .tags(tag_rd), .look_tag, .hit, .hit_way, .victim_way, .victim_tag,
        .touch_en, .touch_set, .touch_way
    );

    ////////////////////////////////////////
    // controller

    l2_ctrl_fsm #(.num_sets(num_sets), .words_per_line(words_per_line)) fsm_i (
        .clk, .reset, .held_req, .held_src, .req_pending, .done, .en,
        .rd_en, .rd_set, .wr_set, .wr_way, .tag_wr_en, .tag_wr_entry,
        .data_wr_en, .data_wr_entry, .data_rd,
        .look_tag, .hit, .hit_way, .victim_way, .victim_tag,
        .touch_en, .touch_set, .touch_way,
        .rsp, .rsp_valid, .rsp_ready,
        .mem_req, .mem_req_valid, .mem_req_ready, .mem_rsp, .mem_rsp_valid, .mem_rsp_ready
    );

endmodule

//--- testbench/l2_mem_model.sv
// one request in flight; untouched lines read back as word address xor a fixed pattern
module l2_mem_model (
    input  logic             clk,
    input  logic             reset,
    input  l2_pkg::mem_req_t mem_req,
    input  logic             mem_req_valid,
    output logic             mem_req_ready,
    output l2_pkg::mem_rsp_t mem_rsp,
    output logic             mem_rsp_valid,
    input  logic             mem_rsp_ready,
    output int               wb_count
);
    import l2_pkg::*;

    localparam word_t fill_xor = 32'hA500_0000;

    line_t  image [int];            // lines written back so far
    integer seed     = 39790;
    int     delay    = 0;
    logic   ready_q  = 1'b0;
    logic   valid_q  = 1'b0;
    line_t  rsp_line = '0;

    assign mem_req_ready = ready_q;
    assign mem_rsp_valid = valid_q;
    assign mem_rsp.data  = rsp_line;

    function automatic line_t fetch_line(int a);
        line_t l;
        if (image.exists(a)) begin
            return image[a];
        end
        for (int w = 0; w < words_per_line; w++) begin
            l[w*word_w +: word_w] = word_t'(a * words_per_line + w) ^ fill_xor;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            ready_q  <= 1'b1;
            valid_q  <= 1'b0;
            wb_count <= 0;
        end else if (mem_req_valid && ready_q) begin
            ready_q <= 1'b0;                            // busy until the beat is taken
            delay   <= $random(seed) & 3;
            if (mem_req.write) begin
                image[int'(mem_req.line_addr)] = mem_req.data;
                wb_count <= wb_count + 1;
                rsp_line <= '0;                         // write ack, data ignored
            end else begin
                rsp_line <= fetch_line(int'(mem_req.line_addr));
            end
        end else if (valid_q && mem_rsp_ready) begin
            valid_q <= 1'b0;
            ready_q <= 1'b1;
        end else if (!ready_q && !valid_q) begin
            if (delay == 0) begin
                valid_q <= 1'b1;
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

//--- testbench/l2_tb.sv
// reads testbench/l2_stim.txt from the project root; at most 32 accesses, one outstanding at a time
module l2_tb;
    import l2_pkg::*;

    localparam int    max_lines = 32;
    localparam int    cols      = 7;                    // tokens per access line
    localparam int    clk_half  = 10;
    localparam word_t fill_xor  = 32'hA500_0000;

    logic     clk       = 1'b0;
    logic     reset     = 1'b1;
    l2_req_t  ic_req    = '0;
    logic     ic_valid  = 1'b0;
    logic     ic_ready;
    l2_req_t  dc_req    = '0;
    logic     dc_valid  = 1'b0;
    logic     dc_ready;
    l2_rsp_t  rsp;
    logic     rsp_valid;
    logic     rsp_ready = 1'b0;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;
    int       wb_count;

    logic [31:0] stim [max_lines*cols];
    word_t       ref_mem [int];                         // words written so far
    int          n_lines = 0;

    always #(clk_half) clk = ~clk;

    l2_cache_top dut_i (
        .clk, .reset, .ic_req, .ic_valid, .ic_ready, .dc_req, .dc_valid, .dc_ready,
        .rsp, .rsp_valid, .rsp_ready,
        .mem_req, .mem_req_valid, .mem_req_ready, .mem_rsp, .mem_rsp_valid, .mem_rsp_ready
    );

    l2_mem_model mem_i (
        .clk, .reset, .mem_req, .mem_req_valid, .mem_req_ready,
        .mem_rsp, .mem_rsp_valid, .mem_rsp_ready, .wb_count
    );

    ////////////////////////////////////////
    // reference and checks

    function automatic word_t ref_word(int addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : word_t'(addr) ^ fill_xor;
    endfunction

    function automatic string rsp_text(l2_rsp_t r);
        return $sformatf("data %h src %0d write %0d", r.data, r.src, r.write);
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(string name, word_t want, word_t got);
        if (got !== want) begin
            stop_run($sformatf("ERROR %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic check_rsp(string name, l2_rsp_t want, l2_rsp_t got);
        if (got !== want) begin
            stop_run($sformatf("ERROR %s expected %s actual %s",
                name, rsp_text(want), rsp_text(got)));
        end
    endtask

    task automatic check_count(string name, int want, int got);
        if (got != want) begin
            stop_run($sformatf("ERROR %s expected %0d actual %0d", name, want, got));
        end
    endtask

    ////////////////////////////////////////
    // request and response handling

    task automatic raise_req(int k);
        l2_req_t r;
        r = '{addr: stim[k*cols+2][addr_w-1:0], write: stim[k*cols+1][0], wdata: stim[k*cols+3]};
        if (stim[k*cols] == 0) begin
            ic_req   <= r;
            ic_valid <= 1'b1;
        end else begin
            dc_req   <= r;
            dc_valid <= 1'b1;
        end
    endtask

    task automatic wait_accept(int k);
        logic on_dc;
        on_dc = stim[k*cols] != 0;
        do begin
            @(posedge clk);
        end while (on_dc ? !(dc_valid && dc_ready) : !(ic_valid && ic_ready));
        if (on_dc) begin
            dc_valid <= 1'b0;
        end else begin
            ic_valid <= 1'b0;
        end
    endtask

    task automatic take_rsp(int k);
        int      b;
        int      addr;
        int      lat;
        string   name;
        l2_rsp_t want;
        l2_rsp_t got;
        b    = k * cols;
        addr = int'(stim[b+2][addr_w-1:0]);
        name = $sformatf("access %0d %s %h", k, stim[b+1][0] ? "wr" : "rd", stim[b+2][15:0]);
        if (stim[b+1][0]) begin
            ref_mem[addr] = stim[b+3];
        end
        want = '{data: stim[b+5], src: stim[b] != 0, write: stim[b+1][0]};
        lat  = 0;
        @(posedge clk);
        while (!rsp_valid) begin                        // edges since the handshake
            lat++;
            @(posedge clk);
        end
        got = rsp;
        if (stim[b+6] != 0) begin
            check_count({name, " latency"}, int'(stim[b+6]), lat);
        end
        check_rsp(name, want, got);
        check_word({name, " image"}, ref_word(addr), got.data);
        repeat (int'(stim[b+4])) begin                  // back-pressure on the response
            @(posedge clk);
            if (!rsp_valid) begin
                stop_run($sformatf("%s: response valid dropped before it was taken", name));
            end
            check_rsp({name, " held"}, got, rsp);
        end
        rsp_ready <= 1'b1;
        @(posedge clk);
        rsp_ready <= 1'b0;
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        int i;
        bit paired;
        foreach (stim[k]) begin
            stim[k] = '1;                               // end marker
        end
        $readmemh("testbench/l2_stim.txt", stim);
        while (n_lines < max_lines && stim[n_lines*cols] != '1) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            stop_run("no accesses found in the stimulus file");
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (num_sets) begin                         // clear sweep still running
            @(posedge clk);
            if (ic_ready || dc_ready || rsp_valid || mem_req_valid) begin
                stop_run("cache became active during the clear sweep after reset");
            end
        end
        i = 0;
        while (i < n_lines) begin
            paired = i + 1 < n_lines && stim[(i+1)*cols] == 2;
            raise_req(i);
            if (paired) begin
                raise_req(i + 1);                       // same edge as the ic request
            end
            wait_accept(i);
            take_rsp(i);
            if (paired) begin
                wait_accept(i + 1);
                take_rsp(i + 1);
            end
            i += paired ? 2 : 1;
        end
        if (wb_count == 0) begin
            stop_run("memory never received a write-back of a dirty line");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

    // reset, clear sweep, then a generous bound per access
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200 + 4 + num_sets * num_ways) @(posedge clk);
        stop_run("watchdog expired before all accesses completed");
    end

endmodule

//--- testbench/l2_stim.txt
// port rw addr wdata hold exp_data latency (hex; port 0 ic, 1 dc, 2 dc raised with the ic line above)
// hold: cycles rsp_ready stays low after rsp_valid; latency 0 means not checked
// first read of a line, then a hit on the same line
0 0 0010 00000000 0 A5000010 0
0 0 0011 00000000 0 A5000011 2
// write hit, read back
1 1 0012 CAFE0012 0 CAFE0012 3
1 0 0012 00000000 0 CAFE0012 2
// write miss, read back
1 1 0200 12345678 0 12345678 0
1 0 0200 00000000 0 12345678 2
// five tags in set 3, then the first tag again
1 1 004C 11110001 0 11110001 0
1 1 008C 22220002 0 22220002 0
1 1 00CC 33330003 0 33330003 0
1 1 010C 44440004 0 44440004 0
1 1 014C 55550005 0 55550005 0
1 0 004C 00000000 0 11110001 0
1 0 004D 00000000 0 A500004D 2
// both ports in the same cycle
0 0 0100 00000000 0 A5000100 0
2 0 0104 00000000 0 A5000104 0
// response back-pressure
1 0 0011 00000000 5 A5000011 2
0 1 0013 BEEF0013 3 BEEF0013 3
0 0 0013 00000000 0 BEEF0013 2
1 1 3FFC 0BADF00D 2 0BADF00D 0
1 0 3FFF 00000000 1 A5003FFF 2

//--- all.f
rtl/l2_pkg.sv
rtl/l2_way_array.sv
rtl/l2_way_select.sv
rtl/l2_req_arbiter.sv
rtl/l2_ctrl_fsm.sv
rtl/l2_cache_top.sv
testbench/l2_mem_model.sv
testbench/l2_tb.sv

//--- Makefile
# Verilator build and run of the L2 cache testbench
VERILATOR ?= verilator
TOP       ?= l2_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# pass or fail comes from the log, not the simulator's exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
